/* flist.f */
rtl/core_pkg.sv
rtl/rs_pkg.sv
rtl/issue_select.sv
rtl/reservation_station.sv
rtl/alu_unit.sv
rtl/mult_unit.sv
rtl/cdb_arbiter.sv
rtl/ooo_issue_top.sv
testbench/tb_clock_gen.sv
testbench/tb_top.sv

/* rtl/alu_unit.sv */
`timescale 1ns/1ps

module alu_unit
    import core_pkg::*;
    import rs_pkg::*;
(
    input  logic              clock,
    input  logic              reset,
    input  logic              issue_valid,
    input  op_t               issue_op,
    input  logic [tag_w-1:0]  issue_dest,
    input  logic [data_w-1:0] issue_a,
    input  logic [data_w-1:0] issue_b,
    input  logic [br_w-1:0]   issue_mask,
    input  logic [br_w-1:0]   br_id,
    input  br_task_t          br_task,
    input  logic              grant,
    output logic              busy,
    output logic              result_valid,
    output logic [tag_w-1:0]  result_tag,
    output logic [data_w-1:0] result_value,
    output logic [br_w-1:0]   result_mask
);

    logic held_valid;
    logic [data_w-1:0] alu_out;

    always_comb begin
        case (issue_op)
            op_add:  alu_out = issue_a + issue_b;
            op_sub:  alu_out = issue_a - issue_b;
            op_and:  alu_out = issue_a & issue_b;
            op_xor:  alu_out = issue_a ^ issue_b;
            default: alu_out = '0;
        endcase
    end

    // A squashed result leaves the CDB request at once
    assign result_valid = held_valid && !(br_task == br_squash && |(result_mask & br_id));
    assign busy = result_valid && !grant;

    always_ff @(posedge clock) begin
        if (reset) begin
            held_valid <= 1'b0;
        end else if (!busy) begin
            held_valid <= issue_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (!busy) begin
            result_tag <= issue_dest;
            result_value <= alu_out;
            result_mask <= issue_mask;
        end else if (br_task == br_clear) begin
            result_mask <= result_mask & ~br_id;
        end
    end

endmodule

/* rtl/cdb_arbiter.sv */
`timescale 1ns/1ps

module cdb_arbiter
    import core_pkg::*;
(
    input  logic                             clock,
    input  logic                             reset,
    input  logic [num_units-1:0]             result_valid,
    input  logic [num_units-1:0][tag_w-1:0]  result_tag,
    input  logic [num_units-1:0][data_w-1:0] result_value,
    output logic [num_units-1:0]             grant,
    output logic                             cdb_valid,
    output logic [tag_w-1:0]                 cdb_tag,
    output logic [data_w-1:0]                cdb_value
);

    logic [unit_w-1:0] last_grant;

    // Search starts just after the last winner
    always_comb begin
        int idx;
        logic found;
        grant = '0;
        found = 1'b0;
        for (int k = 1; k <= num_units; k++) begin
            idx = (int'(last_grant) + k) % num_units;
            if (!found && result_valid[idx]) begin
                grant[idx] = 1'b1;
                found = 1'b1;
            end
        end
    end

    always_comb begin
        cdb_valid = |grant;
        cdb_tag = '0;
        cdb_value = '0;
        for (int u = 0; u < num_units; u++) begin
            if (grant[u]) begin
                cdb_tag = result_tag[u];
                cdb_value = result_value[u];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // alu0 wins first
            last_grant <= unit_w'(num_units - 1);
        end else begin
            for (int u = 0; u < num_units; u++) begin
                if (grant[u]) begin
                    last_grant <= unit_w'(u);
                end
            end
        end
    end

endmodule

/* rtl/core_pkg.sv */
package core_pkg;

    localparam int tag_w = 5;
    localparam int data_w = 16;
    // One-hot branch ids
    localparam int br_w = 4;

    localparam int num_alu = 2;
    localparam int mult_stages = 3;
    // CDB requesters are the ALUs followed by the multiplier
    localparam int num_units = num_alu + 1;
    localparam int unit_w = $clog2(num_units);

    typedef enum logic {
        fu_alu,
        fu_mult
    } fu_class_t;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_xor,
        op_mul
    } op_t;

endpackage

/* rtl/issue_select.sv */
`timescale 1ns/1ps

module issue_select
    import rs_pkg::*;
#(
    parameter int num_fu = 2
) (
    input  logic [rs_depth-1:0]             ready_mask,
    input  logic [num_fu-1:0]               fu_free,
    output logic [num_fu-1:0][rs_depth-1:0] grant
);

    // Ready entries not yet taken by a lower-numbered unit
    logic [rs_depth-1:0] remaining;

    always_comb begin
        remaining = ready_mask;
        grant = '0;
        for (int f = 0; f < num_fu; f++) begin
            if (fu_free[f]) begin
                // Lowest set bit only
                grant[f] = remaining & (~remaining + 1'b1);
                remaining = remaining & ~grant[f];
            end
        end
    end

endmodule

/* rtl/mult_unit.sv */
`timescale 1ns/1ps

module mult_unit
    import core_pkg::*;
    import rs_pkg::*;
(
    input  logic              clock,
    input  logic              reset,
    input  logic              issue_valid,
    input  op_t               issue_op,
    input  logic [tag_w-1:0]  issue_dest,
    input  logic [data_w-1:0] issue_a,
    input  logic [data_w-1:0] issue_b,
    input  logic [br_w-1:0]   issue_mask,
    input  logic [br_w-1:0]   br_id,
    input  br_task_t          br_task,
    input  logic              grant,
    output logic              busy,
    output logic              result_valid,
    output logic [tag_w-1:0]  result_tag,
    output logic [data_w-1:0] result_value,
    output logic [br_w-1:0]   result_mask
);

    logic [mult_stages-1:0] st_valid;
    logic [mult_stages-1:0] st_live;
    logic [mult_stages-1:0][tag_w-1:0] st_tag;
    logic [mult_stages-1:0][data_w-1:0] st_value;
    logic [mult_stages-1:0][br_w-1:0] st_mask;
    logic [mult_stages-1:0][br_w-1:0] st_mask_kept;
    logic [data_w-1:0] product;

    // Low half of the product
    assign product = (issue_op == op_mul) ? issue_a * issue_b : '0;

    // Branch outcome applied to every stage
    always_comb begin
        for (int s = 0; s < mult_stages; s++) begin
            st_live[s] = st_valid[s] && !(br_task == br_squash && |(st_mask[s] & br_id));
            st_mask_kept[s] = (br_task == br_clear) ? st_mask[s] & ~br_id : st_mask[s];
        end
    end

    assign result_valid = st_live[mult_stages-1];
    assign result_tag = st_tag[mult_stages-1];
    assign result_value = st_value[mult_stages-1];
    assign result_mask = st_mask[mult_stages-1];

    // Whole pipe freezes while the last stage waits for the CDB
    assign busy = result_valid && !grant;

    always_ff @(posedge clock) begin
        if (reset) begin
            st_valid <= '0;
        end else if (busy) begin
            st_valid <= st_live;
        end else begin
            st_valid <= {st_live[mult_stages-2:0], issue_valid};
        end
    end

    always_ff @(posedge clock) begin
        if (busy) begin
            st_mask <= st_mask_kept;
        end else begin
            st_tag <= {st_tag[mult_stages-2:0], issue_dest};
            st_value <= {st_value[mult_stages-2:0], product};
            st_mask <= {st_mask_kept[mult_stages-2:0], issue_mask};
        end
    end

endmodule

/* rtl/ooo_issue_top.sv */
`timescale 1ns/1ps

module ooo_issue_top
    import core_pkg::*;
    import rs_pkg::*;
(
    input  logic              clock,
    input  logic              reset,
    input  logic              dispatch_valid,
    input  fu_class_t         dispatch_class,
    input  op_t               dispatch_op,
    input  logic [tag_w-1:0]  dispatch_dest,
    input  logic [tag_w-1:0]  src1_tag,
    input  logic              src1_ready,
    input  logic [data_w-1:0] src1_value,
    input  logic [tag_w-1:0]  src2_tag,
    input  logic              src2_ready,
    input  logic [data_w-1:0] src2_value,
    input  logic [br_w-1:0]   dispatch_mask,
    input  logic [br_w-1:0]   br_id,
    input  br_task_t          br_task,
    output logic              rs_full,
    output logic              cdb_valid,
    output logic [tag_w-1:0]  cdb_tag,
    output logic [data_w-1:0] cdb_value
);

    logic [num_alu-1:0] alu_busy;
    logic mult_busy;

    logic [num_alu-1:0] alu_issue_valid;
    op_t [num_alu-1:0] alu_issue_op;
    logic [num_alu-1:0][tag_w-1:0] alu_issue_dest;
    logic [num_alu-1:0][data_w-1:0] alu_issue_a;
    logic [num_alu-1:0][data_w-1:0] alu_issue_b;
    logic [num_alu-1:0][br_w-1:0] alu_issue_mask;

    logic mult_issue_valid;
    op_t mult_issue_op;
    logic [tag_w-1:0] mult_issue_dest;
    logic [data_w-1:0] mult_issue_a;
    logic [data_w-1:0] mult_issue_b;
    logic [br_w-1:0] mult_issue_mask;

    // CDB requesters, ALUs first
    logic [num_units-1:0] result_valid;
    logic [num_units-1:0][tag_w-1:0] result_tag;
    logic [num_units-1:0][data_w-1:0] result_value;
    logic [num_units-1:0] grant;

    reservation_station rs (.*);

    for (genvar i = 0; i < num_alu; i++) begin : gen_alu
        alu_unit alu (
            .clock        (clock),
            .reset        (reset),
            .issue_valid  (alu_issue_valid[i]),
            .issue_op     (alu_issue_op[i]),
            .issue_dest   (alu_issue_dest[i]),
            .issue_a      (alu_issue_a[i]),
            .issue_b      (alu_issue_b[i]),
            .issue_mask   (alu_issue_mask[i]),
            .br_id        (br_id),
            .br_task      (br_task),
            .grant        (grant[i]),
            .busy         (alu_busy[i]),
            .result_valid (result_valid[i]),
            .result_tag   (result_tag[i]),
            .result_value (result_value[i]),
            .result_mask  ()
        );
    end

    mult_unit mult (
        .clock        (clock),
        .reset        (reset),
        .issue_valid  (mult_issue_valid),
        .issue_op     (mult_issue_op),
        .issue_dest   (mult_issue_dest),
        .issue_a      (mult_issue_a),
        .issue_b      (mult_issue_b),
        .issue_mask   (mult_issue_mask),
        .br_id        (br_id),
        .br_task      (br_task),
        .grant        (grant[num_alu]),
        .busy         (mult_busy),
        .result_valid (result_valid[num_alu]),
        .result_tag   (result_tag[num_alu]),
        .result_value (result_value[num_alu]),
        .result_mask  ()
    );

    cdb_arbiter arbiter (.*);

endmodule

/* rtl/reservation_station.sv */
`timescale 1ns/1ps

module reservation_station
    import core_pkg::*;
    import rs_pkg::*;
(
    input  logic                           clock,
    input  logic                           reset,

    input  logic                           dispatch_valid,
    input  fu_class_t                      dispatch_class,
    input  op_t                            dispatch_op,
    input  logic [tag_w-1:0]               dispatch_dest,
    input  logic [tag_w-1:0]               src1_tag,
    input  logic                           src1_ready,
    input  logic [data_w-1:0]              src1_value,
    input  logic [tag_w-1:0]               src2_tag,
    input  logic                           src2_ready,
    input  logic [data_w-1:0]              src2_value,
    input  logic [br_w-1:0]                dispatch_mask,
    output logic                           rs_full,

    input  logic [br_w-1:0]                br_id,
    input  br_task_t                       br_task,

    input  logic                           cdb_valid,
    input  logic [tag_w-1:0]               cdb_tag,
    input  logic [data_w-1:0]              cdb_value,

    input  logic [num_alu-1:0]             alu_busy,
    input  logic                           mult_busy,

    output logic [num_alu-1:0]             alu_issue_valid,
    output op_t  [num_alu-1:0]             alu_issue_op,
    output logic [num_alu-1:0][tag_w-1:0]  alu_issue_dest,
    output logic [num_alu-1:0][data_w-1:0] alu_issue_a,
    output logic [num_alu-1:0][data_w-1:0] alu_issue_b,
    output logic [num_alu-1:0][br_w-1:0]   alu_issue_mask,

    output logic                           mult_issue_valid,
    output op_t                            mult_issue_op,
    output logic [tag_w-1:0]               mult_issue_dest,
    output logic [data_w-1:0]              mult_issue_a,
    output logic [data_w-1:0]              mult_issue_b,
    output logic [br_w-1:0]                mult_issue_mask
);

    rs_entry_t entries [rs_depth];
    rs_entry_t next_entries [rs_depth];
    rs_entry_t new_entry;
    rs_entry_t pkt [num_units];

    logic [rs_depth-1:0] valid_vec;
    logic [rs_depth-1:0] alu_ready;
    logic [rs_depth-1:0] mult_ready;
    logic [rs_depth-1:0] issued;
    logic [rs_depth-1:0] free_slot;
    logic [num_alu-1:0][rs_depth-1:0] alu_grant;
    logic [0:0][rs_depth-1:0] mult_grant;
    logic [num_units-1:0][rs_depth-1:0] unit_grant;
    logic [num_units-1:0] pkt_live;
    logic [num_units-1:0][br_w-1:0] pkt_mask;
    logic squash_now;
    logic clear_now;
    logic full_next;

    assign squash_now = br_task == br_squash;
    assign clear_now = br_task == br_clear;

    always_comb begin
        logic ready;
        for (int e = 0; e < rs_depth; e++) begin
            ready = entries[e].valid && entries[e].src1_ready && entries[e].src2_ready;
            valid_vec[e] = entries[e].valid;
            alu_ready[e] = ready && entries[e].fu_class == fu_alu;
            mult_ready[e] = ready && entries[e].fu_class == fu_mult;
        end
    end

    issue_select #(.num_fu(num_alu)) alu_select (
        .ready_mask (alu_ready),
        .fu_free    (~alu_busy),
        .grant      (alu_grant)
    );

    issue_select #(.num_fu(1)) mult_select (
        .ready_mask (mult_ready),
        .fu_free    (~mult_busy),
        .grant      (mult_grant)
    );

    // Same unit order as the CDB requesters
    assign unit_grant = {mult_grant, alu_grant};

    // Outgoing packets, with this cycle's branch outcome applied
    always_comb begin
        issued = '0;
        for (int u = 0; u < num_units; u++) begin
            issued = issued | unit_grant[u];
            pkt[u] = '0;
            for (int e = 0; e < rs_depth; e++) begin
                if (unit_grant[u][e]) begin
                    pkt[u] = entries[e];
                end
            end
            pkt_live[u] = pkt[u].valid && !(squash_now && |(pkt[u].mask & br_id));
            pkt_mask[u] = clear_now ? pkt[u].mask & ~br_id : pkt[u].mask;
        end
    end

    always_comb begin
        for (int f = 0; f < num_alu; f++) begin
            alu_issue_valid[f] = pkt_live[f];
            alu_issue_op[f] = pkt[f].op;
            alu_issue_dest[f] = pkt[f].dest;
            alu_issue_a[f] = pkt[f].src1_value;
            alu_issue_b[f] = pkt[f].src2_value;
            alu_issue_mask[f] = pkt_mask[f];
        end
    end

    assign mult_issue_valid = pkt_live[num_alu];
    assign mult_issue_op = pkt[num_alu].op;
    assign mult_issue_dest = pkt[num_alu].dest;
    assign mult_issue_a = pkt[num_alu].src1_value;
    assign mult_issue_b = pkt[num_alu].src2_value;
    assign mult_issue_mask = pkt_mask[num_alu];

    // Lowest invalid slot, one-hot
    assign free_slot = ~valid_vec & (valid_vec + 1'b1);

    always_comb begin
        new_entry.valid = 1'b1;
        new_entry.fu_class = dispatch_class;
        new_entry.op = dispatch_op;
        new_entry.dest = dispatch_dest;
        new_entry.src1_tag = src1_tag;
        new_entry.src1_ready = src1_ready;
        new_entry.src1_value = src1_value;
        new_entry.src2_tag = src2_tag;
        new_entry.src2_ready = src2_ready;
        new_entry.src2_value = src2_value;
        new_entry.mask = dispatch_mask;
        // Producer broadcasting in the dispatch cycle
        if (cdb_valid && !src1_ready && src1_tag == cdb_tag) begin
            new_entry.src1_ready = 1'b1;
            new_entry.src1_value = cdb_value;
        end
        if (cdb_valid && !src2_ready && src2_tag == cdb_tag) begin
            new_entry.src2_ready = 1'b1;
            new_entry.src2_value = cdb_value;
        end
    end

    always_comb begin
        full_next = 1'b1;
        for (int e = 0; e < rs_depth; e++) begin
            next_entries[e] = entries[e];
            if (cdb_valid && !entries[e].src1_ready && entries[e].src1_tag == cdb_tag) begin
                next_entries[e].src1_ready = 1'b1;
                next_entries[e].src1_value = cdb_value;
            end
            if (cdb_valid && !entries[e].src2_ready && entries[e].src2_tag == cdb_tag) begin
                next_entries[e].src2_ready = 1'b1;
                next_entries[e].src2_value = cdb_value;
            end
            if (issued[e]) begin
                next_entries[e].valid = 1'b0;
            end
            if (dispatch_valid && free_slot[e]) begin
                next_entries[e] = new_entry;
            end
            if (squash_now && |(next_entries[e].mask & br_id)) begin
                next_entries[e].valid = 1'b0;
            end
            if (clear_now) begin
                next_entries[e].mask = next_entries[e].mask & ~br_id;
            end
            full_next = full_next && next_entries[e].valid;
        end
    end

    always_ff @(posedge clock) begin
        entries <= next_entries;
        if (reset) begin
            for (int e = 0; e < rs_depth; e++) begin
                entries[e].valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            rs_full <= 1'b0;
        end else begin
            rs_full <= full_next;
        end
    end

endmodule

/* rtl/rs_pkg.sv */
package rs_pkg;

    import core_pkg::*;

    localparam int rs_depth = 8;

    typedef enum logic [1:0] {
        br_none,
        br_clear,
        br_squash
    } br_task_t;

    typedef struct packed {
        logic              valid;
        fu_class_t         fu_class;
        op_t               op;
        logic [tag_w-1:0]  dest;
        logic [tag_w-1:0]  src1_tag;
        logic              src1_ready;
        logic [data_w-1:0] src1_value;
        logic [tag_w-1:0]  src2_tag;
        logic              src2_ready;
        logic [data_w-1:0] src2_value;
        logic [br_w-1:0]   mask;
    } rs_entry_t;

endpackage

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f flist.f -o tb_top_sim \
    && ./obj_dir/tb_top_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q "ALL TESTS PASSED" sim.log && exit 0 || exit 1

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    localparam real half_period = 2.0;

    initial begin
        clock = 1'b0;
        forever #(half_period) clock = ~clock;
    end

    // Reset released on a falling edge, like the other inputs
    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

/* testbench/tb_top.sv */
`timescale 1ns/1ps

module tb_top
    import core_pkg::*;
    import rs_pkg::*;
();

    localparam int num_dispatch = 300;
    localparam int timeout_limit = num_dispatch * 40;
    localparam int num_tags = 1 << tag_w;
    localparam logic [15:0] lfsr_seed = 16'd47;
    localparam int st_done = 0;
    localparam int st_live = 1;
    localparam int st_squashed = 2;

    logic clock;
    logic reset;
    logic dispatch_valid;
    fu_class_t dispatch_class;
    op_t dispatch_op;
    logic [tag_w-1:0] dispatch_dest;
    logic [tag_w-1:0] src1_tag;
    logic src1_ready;
    logic [data_w-1:0] src1_value;
    logic [tag_w-1:0] src2_tag;
    logic src2_ready;
    logic [data_w-1:0] src2_value;
    logic [br_w-1:0] dispatch_mask;
    logic [br_w-1:0] br_id;
    br_task_t br_task;
    logic rs_full;
    logic cdb_valid;
    logic [tag_w-1:0] cdb_tag;
    logic [data_w-1:0] cdb_value;

    // Reference model indexed by tag
    int tag_state [num_tags];
    int dispatch_count [num_tags];
    op_t tag_op [num_tags];
    logic [br_w-1:0] tag_mask [num_tags];
    logic [data_w-1:0] tag_value [num_tags];
    logic [tag_w-1:0] src_tag [num_tags][2];
    logic src_known [num_tags][2];
    logic [data_w-1:0] src_val [num_tags][2];
    int pool_q [$];
    int live_q [$];
    // Open branch bits from oldest to youngest
    int br_order [$];

    logic [15:0] lfsr;
    int value_errors;
    int other_errors;
    int dispatched;
    int completed;
    int squashed;
    int cycle_count;
    logic full_seen;

    tb_clock_gen clock_gen (
        .clock (clock),
        .reset (reset)
    );

    ooo_issue_top uut (.*);

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        // Galois form with taps 16 14 13 11
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    function automatic int random_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
        return value;
    endfunction

    function automatic logic [data_w-1:0] expected_result(input op_t op,
            input logic [data_w-1:0] a, input logic [data_w-1:0] b);
        logic [2*data_w-1:0] full_product;
        full_product = a * b;
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_xor:  return a ^ b;
            default: return full_product[data_w-1:0];
        endcase
    endfunction

    function automatic logic [br_w-1:0] open_mask();
        logic [br_w-1:0] m;
        m = '0;
        foreach (br_order[i]) begin
            m[br_order[i]] = 1'b1;
        end
        return m;
    endfunction

    task automatic drop_live(input int t);
        for (int i = 0; i < live_q.size(); i++) begin
            if (live_q[i] == t) begin
                live_q.delete(i);
                break;
            end
        end
        pool_q.push_back(t);
    endtask

    task automatic pick_source(input logic newest, output logic [tag_w-1:0] tag,
            output logic ready, output logic [data_w-1:0] value);
        int start;
        int t;
        logic found;
        tag = '0;
        ready = 1'b1;
        value = '0;
        found = 1'b0;
        if (live_q.size() > 0 && (newest || random_bits(1) == 1)) begin
            t = newest ? live_q[live_q.size()-1] : live_q[random_bits(8) % live_q.size()];
            tag = tag_w'(t);
            ready = 1'b0;
        end else begin
            // A finished tag or a plain value when none is left
            start = random_bits(tag_w);
            for (int k = 0; k < num_tags; k++) begin
                t = (start + k) % num_tags;
                if (!found && tag_state[t] == st_done) begin
                    tag = tag_w'(t);
                    value = tag_value[t];
                    found = 1'b1;
                end
            end
            if (!found) begin
                tag = tag_w'(start);
                value = data_w'(random_bits(data_w));
            end
        end
    endtask

    task automatic dispatch_one(input logic burst);
        int dest;
        op_t op;
        fu_class_t cls;
        logic [tag_w-1:0] t1;
        logic [tag_w-1:0] t2;
        logic r1;
        logic r2;
        logic [data_w-1:0] v1;
        logic [data_w-1:0] v2;
        dest = pool_q.pop_front();
        if (burst || random_bits(2) == 0) begin
            cls = fu_mult;
            op = op_mul;
        end else begin
            cls = fu_alu;
            op = op_t'(random_bits(2));
        end
        // Bursts chain each multiply on the newest result so the station fills
        pick_source(burst, t1, r1, v1);
        pick_source(1'b0, t2, r2, v2);
        tag_state[dest] = st_live;
        dispatch_count[dest]++;
        tag_op[dest] = op;
        tag_mask[dest] = open_mask();
        src_tag[dest][0] = t1;
        src_known[dest][0] = r1;
        src_val[dest][0] = v1;
        src_tag[dest][1] = t2;
        src_known[dest][1] = r2;
        src_val[dest][1] = v2;
        live_q.push_back(dest);
        dispatch_valid = 1'b1;
        dispatch_class = cls;
        dispatch_op = op;
        dispatch_dest = tag_w'(dest);
        src1_tag = t1;
        src1_ready = r1;
        src1_value = v1;
        src2_tag = t2;
        src2_ready = r2;
        src2_value = v2;
        dispatch_mask = tag_mask[dest];
        dispatched++;
    endtask

    task automatic branch_event();
        int r;
        int idx;
        int b;
        int t;
        logic [br_w-1:0] open_bits;
        r = random_bits(4);
        open_bits = open_mask();
        if (r == 0 && br_order.size() < br_w) begin
            b = random_bits($clog2(br_w));
            while (open_bits[b]) begin
                b = (b + 1) % br_w;
            end
            br_order.push_back(b);
        end else if (r == 1 && br_order.size() > 0) begin
            idx = random_bits(2) % br_order.size();
            b = br_order[idx];
            br_id = '0;
            br_id[b] = 1'b1;
            if (random_bits(1) == 1) begin
                br_task = br_squash;
                // Younger branches die with it
                while (br_order.size() > idx) begin
                    void'(br_order.pop_back());
                end
                for (int i = live_q.size() - 1; i >= 0; i--) begin
                    t = live_q[i];
                    if (tag_mask[t][b]) begin
                        tag_state[t] = st_squashed;
                        live_q.delete(i);
                        pool_q.push_back(t);
                        squashed++;
                    end
                end
            end else begin
                br_task = br_clear;
                br_order.delete(idx);
                foreach (live_q[i]) begin
                    tag_mask[live_q[i]][b] = 1'b0;
                end
            end
        end
    endtask

    task automatic check_cdb();
        int t;
        logic [data_w-1:0] expected;
        if (cdb_valid) begin
            t = int'(cdb_tag);
            assert (tag_state[t] == st_live) else begin
                other_errors++;
                if (dispatch_count[t] == 0) begin
                    $display("Tag %0d appeared on the CDB but was never dispatched", t);
                end else if (tag_state[t] == st_squashed) begin
                    $display("Tag %0d appeared on the CDB after its branch was squashed", t);
                end else begin
                    $display("Tag %0d appeared on the CDB a second time", t);
                end
            end
            if (tag_state[t] == st_live) begin
                assert (src_known[t][0] && src_known[t][1]) else begin
                    other_errors++;
                    $display("Tag %0d was broadcast before its producers", t);
                end
                expected = expected_result(tag_op[t], src_val[t][0], src_val[t][1]);
                assert (cdb_value == expected) else begin
                    value_errors++;
                    $display("Mismatch cdb_value for tag 0x%h: got 0x%h, expected 0x%h",
                        cdb_tag, cdb_value, expected);
                end
                tag_state[t] = st_done;
                tag_value[t] = expected;
                completed++;
                drop_live(t);
                // Consumers waiting on this tag
                foreach (live_q[i]) begin
                    for (int s = 0; s < 2; s++) begin
                        if (!src_known[live_q[i]][s] && src_tag[live_q[i]][s] == cdb_tag) begin
                            src_known[live_q[i]][s] = 1'b1;
                            src_val[live_q[i]][s] = expected;
                        end
                    end
                end
            end
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout after %0d cycles with %0d outstanding, errors: %0d value, %0d other",
            timeout_limit, live_q.size(), value_errors, other_errors);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        logic burst;
        dispatch_valid = 1'b0;
        dispatch_class = fu_alu;
        dispatch_op = op_add;
        dispatch_dest = '0;
        src1_tag = '0;
        src1_ready = 1'b0;
        src1_value = '0;
        src2_tag = '0;
        src2_ready = 1'b0;
        src2_value = '0;
        dispatch_mask = '0;
        br_id = '0;
        br_task = br_none;
        lfsr = lfsr_seed;
        value_errors = 0;
        other_errors = 0;
        dispatched = 0;
        completed = 0;
        squashed = 0;
        full_seen = 1'b0;
        // Every tag starts as a finished register with a known value
        for (int t = 0; t < num_tags; t++) begin
            tag_state[t] = st_done;
            dispatch_count[t] = 0;
            tag_value[t] = data_w'(random_bits(data_w));
            pool_q.push_back(t);
        end
        wait (reset == 1'b1);
        wait (reset == 1'b0);
        @(negedge clock);
        assert (!rs_full && !cdb_valid) else begin
            other_errors++;
            $display("rs_full or cdb_valid is high after reset");
        end
        while (dispatched < num_dispatch || live_q.size() > 0) begin
            @(negedge clock);
            burst = (dispatched >= 100 && dispatched < 130)
                || (dispatched >= 220 && dispatched < 245);
            dispatch_valid = 1'b0;
            br_task = br_none;
            br_id = '0;
            full_seen = full_seen | rs_full;
            if (dispatched < num_dispatch && !burst) begin
                branch_event();
            end
            if (dispatched < num_dispatch && !rs_full && pool_q.size() > 0
                    && (burst || random_bits(2) != 0)) begin
                dispatch_one(burst);
            end
            #1;
            check_cdb();
        end
        // Nothing may reach the CDB in the quiet tail
        repeat (10) begin
            @(negedge clock);
            dispatch_valid = 1'b0;
            br_task = br_none;
            br_id = '0;
            #1;
            check_cdb();
        end
        assert (full_seen) else begin
            other_errors++;
            $display("rs_full never rose during the multiply bursts");
        end
        $display("Errors: %0d value, %0d other (%0d dispatched, %0d completed, %0d squashed)",
            value_errors, other_errors, dispatched, completed, squashed);
        if (value_errors + other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
